// ==== amo_lsu.f ====
hw/amo_lsu_pkg.sv
hw/store_buffer.sv
hw/amo_buffer.sv
hw/amo_mem_unit.sv
hw/amo_lsu_top.sv
verification/amo_lsu_properties.sv
verification/amo_lsu_tb.sv

// ==== hw/amo_buffer.sv ====
/*
 * One-entry AMO holding register between issue and the memory unit
 * Request goes out only with the AMO at commit and the store queue empty
 * Flush is ignored once the commit stage holds the AMO
 */
`default_nettype none

module amo_buffer
    import amo_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            flush_i,

    input  logic            amo_valid_i,
    input  amo_op_e         amo_op_i,
    input  logic [PLEN-1:0] amo_paddr_i,
    input  logic [XLEN-1:0] amo_data_i,
    input  logic [1:0]      amo_size_i,
    output logic            amo_ready_o,         // Entry free

    input  logic            amo_valid_commit_i,  // Level, AMO sits in commit
    input  logic            no_st_pending_i,

    output logic            amo_req_o,           // Held until ack
    output amo_op_e         amo_req_op_o,
    output logic [PLEN-1:0] amo_req_paddr_o,
    output logic [XLEN-1:0] amo_req_data_o,
    output logic [1:0]      amo_req_size_o,
    input  logic            amo_ack_i            // Pops the entry
);

    logic            valid_q;
    amo_op_e         op_q;
    logic [PLEN-1:0] paddr_q;
    logic [XLEN-1:0] data_q;
    logic [1:0]      size_q;
    logic            flush_amo;
    logic            push;

    assign flush_amo   = flush_i & ~amo_valid_commit_i;  // Still speculative
    assign amo_ready_o = ~valid_q;
    assign push        = amo_valid_i & ~valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (flush_amo || amo_ack_i) begin
            valid_q <= 1'b0;  // Also drops a push racing the flush
        end else if (push) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            op_q    <= amo_op_i;
            paddr_q <= amo_paddr_i;
            data_q  <= amo_data_i;
            size_q  <= amo_size_i;
        end
    end

    assign amo_req_o       = valid_q & amo_valid_commit_i & no_st_pending_i;
    assign amo_req_op_o    = op_q;
    assign amo_req_paddr_o = paddr_q;
    assign amo_req_data_o  = data_q;
    assign amo_req_size_o  = size_q;

endmodule

`default_nettype wire

// ==== hw/amo_lsu_pkg.sv ====
/*
 * Shared constants and the AMO opcode set of the load/store AMO path
 * Data path is fixed at 64 bits, only word and doubleword sizes exist
 * Memory index comes from paddr[6:3], paddr[2] picks the word half
 */
`default_nettype none

package amo_lsu_pkg;

    localparam int PLEN        = 12;  // Physical address width
    localparam int XLEN        = 64;  // Data width
    localparam int MEM_WORDS   = 16;  // Doublewords in the data memory
    localparam int STORE_DEPTH = 4;   // Must stay a power of two for pointer wrap

    localparam int MEM_IDX_W = $clog2(MEM_WORDS);    // Doubleword index bits
    localparam int SB_PTR_W  = $clog2(STORE_DEPTH);  // Store queue pointer bits
    localparam int SB_CNT_W  = SB_PTR_W + 1;         // Occupancy count, holds STORE_DEPTH

    // Access size codes, RISC-V style
    localparam logic [1:0] SIZE_W = 2'd2;  // 32 bit
    localparam logic [1:0] SIZE_D = 2'd3;  // 64 bit

    // AMO operations handled by the memory unit ALU
    typedef enum logic [3:0] {
        AMO_NONE = 4'h0,
        AMO_SWAP = 4'h1,
        AMO_ADD  = 4'h2,
        AMO_AND  = 4'h3,
        AMO_OR   = 4'h4,
        AMO_XOR  = 4'h5,
        AMO_MAX  = 4'h6,  // Signed
        AMO_MAXU = 4'h7,
        AMO_MIN  = 4'h8,  // Signed
        AMO_MINU = 4'h9
    } amo_op_e;

endpackage

`default_nettype wire

// ==== hw/amo_lsu_top.sv ====
/*
 * AMO path of the load/store unit, store queue and AMO buffer over one memory
 * Loads read memory only, pending stores are not forwarded
 */
`default_nettype none

module amo_lsu_top
    import amo_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            flush_i,

    // Store issue and commit
    input  logic            st_valid_i,
    input  logic [PLEN-1:0] st_paddr_i,
    input  logic [XLEN-1:0] st_data_i,
    input  logic [1:0]      st_size_i,
    input  logic            st_commit_i,
    output logic            st_ready_o,

    // AMO issue, commit and response
    input  logic            amo_valid_i,
    input  amo_op_e         amo_op_i,
    input  logic [PLEN-1:0] amo_paddr_i,
    input  logic [XLEN-1:0] amo_data_i,
    input  logic [1:0]      amo_size_i,
    output logic            amo_ready_o,
    input  logic            amo_valid_commit_i,
    output logic            amo_ack_o,
    output logic [XLEN-1:0] amo_result_o,

    // Load port
    input  logic            ld_req_i,
    input  logic [PLEN-1:0] ld_paddr_i,
    output logic [XLEN-1:0] ld_data_o
);

    logic            drain_valid;
    logic [PLEN-1:0] drain_paddr;
    logic [XLEN-1:0] drain_data;
    logic [1:0]      drain_size;
    logic            drain_done;
    logic            no_st_pending;

    logic            amo_req;
    amo_op_e         amo_req_op;
    logic [PLEN-1:0] amo_req_paddr;
    logic [XLEN-1:0] amo_req_data;
    logic [1:0]      amo_req_size;
    logic            amo_ack;         // Pops the AMO buffer and leaves the top

    assign amo_ack_o = amo_ack;

    store_buffer i_store_buffer (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .st_valid_i      (st_valid_i),
        .st_paddr_i      (st_paddr_i),
        .st_data_i       (st_data_i),
        .st_size_i       (st_size_i),
        .st_commit_i     (st_commit_i),
        .st_ready_o      (st_ready_o),
        .drain_valid_o   (drain_valid),
        .drain_paddr_o   (drain_paddr),
        .drain_data_o    (drain_data),
        .drain_size_o    (drain_size),
        .drain_done_i    (drain_done),
        .no_st_pending_o (no_st_pending)
    );

    amo_buffer i_amo_buffer (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .flush_i            (flush_i),
        .amo_valid_i        (amo_valid_i),
        .amo_op_i           (amo_op_i),
        .amo_paddr_i        (amo_paddr_i),
        .amo_data_i         (amo_data_i),
        .amo_size_i         (amo_size_i),
        .amo_ready_o        (amo_ready_o),
        .amo_valid_commit_i (amo_valid_commit_i),
        .no_st_pending_i    (no_st_pending),
        .amo_req_o          (amo_req),
        .amo_req_op_o       (amo_req_op),
        .amo_req_paddr_o    (amo_req_paddr),
        .amo_req_data_o     (amo_req_data),
        .amo_req_size_o     (amo_req_size),
        .amo_ack_i          (amo_ack)
    );

    amo_mem_unit i_amo_mem_unit (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .drain_valid_i   (drain_valid),
        .drain_paddr_i   (drain_paddr),
        .drain_data_i    (drain_data),
        .drain_size_i    (drain_size),
        .drain_done_o    (drain_done),
        .amo_req_i       (amo_req),
        .amo_req_op_i    (amo_req_op),
        .amo_req_paddr_i (amo_req_paddr),
        .amo_req_data_i  (amo_req_data),
        .amo_req_size_i  (amo_req_size),
        .amo_ack_o       (amo_ack),
        .amo_result_o    (amo_result_o),
        .ld_req_i        (ld_req_i),
        .ld_paddr_i      (ld_paddr_i),
        .ld_data_o       (ld_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/amo_mem_unit.sv ====
/*
 * 16 x 64 bit data memory shared by store drain, AMOs and loads
 * AMO takes two cycles, read then modify and write, ack one edge later
 * Drains stall while an AMO is requested, so one write port suffices
 * Loads read registered memory and see the value before any same-cycle write
 */
`default_nettype none

module amo_mem_unit
    import amo_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,

    input  logic            drain_valid_i,
    input  logic [PLEN-1:0] drain_paddr_i,
    input  logic [XLEN-1:0] drain_data_i,
    input  logic [1:0]      drain_size_i,
    output logic            drain_done_o,    // Same cycle as the write

    input  logic            amo_req_i,       // Payload stable while high
    input  amo_op_e         amo_req_op_i,
    input  logic [PLEN-1:0] amo_req_paddr_i,
    input  logic [XLEN-1:0] amo_req_data_i,
    input  logic [1:0]      amo_req_size_i,
    output logic            amo_ack_o,       // One-cycle pulse
    output logic [XLEN-1:0] amo_result_o,    // Old memory value

    input  logic            ld_req_i,
    input  logic [PLEN-1:0] ld_paddr_i,
    output logic [XLEN-1:0] ld_data_o        // Valid one cycle after ld_req_i
);

    logic [XLEN-1:0] mem_q [MEM_WORDS];

    logic            amo_phase_q;   // Read done, modify and write now
    logic            amo_ack_q;
    logic [XLEN-1:0] amo_old_q;     // Doubleword read in the first cycle
    logic [XLEN-1:0] amo_result_q;
    logic [XLEN-1:0] ld_data_q;

    logic                 amo_start;
    logic                 amo_active;
    logic                 amo_word;
    logic [MEM_IDX_W-1:0] drain_idx;
    logic [MEM_IDX_W-1:0] amo_idx;
    logic [MEM_IDX_W-1:0] ld_idx;
    logic [31:0]          old_half;
    logic [XLEN-1:0]      op_a;     // Old value, sign-extended for words
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_res;
    logic [XLEN-1:0]      amo_wdata;
    logic [XLEN-1:0]      drain_wdata;

    assign drain_idx = drain_paddr_i[MEM_IDX_W+2:3];
    assign amo_idx   = amo_req_paddr_i[MEM_IDX_W+2:3];
    assign ld_idx    = ld_paddr_i[MEM_IDX_W+2:3];

    // No restart while the ack is out, req drops right after it
    assign amo_start  = amo_req_i & ~amo_phase_q & ~amo_ack_q;
    assign amo_active = amo_req_i | amo_phase_q;

    assign drain_done_o = drain_valid_i & ~amo_active;

    // Store merge, a word store keeps the other half
    always_comb begin
        drain_wdata = mem_q[drain_idx];
        if (drain_size_i == SIZE_D) begin
            drain_wdata = drain_data_i;
        end else if (drain_paddr_i[2]) begin
            drain_wdata[63:32] = drain_data_i[31:0];
        end else begin
            drain_wdata[31:0] = drain_data_i[31:0];
        end
    end

    // Sign-extended word operands keep both signed and unsigned order intact
    assign amo_word = amo_req_size_i == SIZE_W;
    assign old_half = amo_req_paddr_i[2] ? amo_old_q[63:32] : amo_old_q[31:0];
    assign op_a     = amo_word ? {{32{old_half[31]}}, old_half} : amo_old_q;
    assign op_b     = amo_word ? {{32{amo_req_data_i[31]}}, amo_req_data_i[31:0]}
                               : amo_req_data_i;

    always_comb begin
        case (amo_req_op_i)
            AMO_SWAP: alu_res = op_b;
            AMO_ADD:  alu_res = op_a + op_b;
            AMO_AND:  alu_res = op_a & op_b;
            AMO_OR:   alu_res = op_a | op_b;
            AMO_XOR:  alu_res = op_a ^ op_b;
            AMO_MAX:  alu_res = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
            AMO_MAXU: alu_res = (op_a > op_b) ? op_a : op_b;
            AMO_MIN:  alu_res = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
            AMO_MINU: alu_res = (op_a < op_b) ? op_a : op_b;
            default:  alu_res = op_a;  // AMO_NONE leaves memory as is
        endcase
    end

    // Word result goes back into its own half
    always_comb begin
        amo_wdata = alu_res;
        if (amo_word) begin
            amo_wdata = amo_req_paddr_i[2] ? {alu_res[31:0], amo_old_q[31:0]}
                                           : {amo_old_q[63:32], alu_res[31:0]};
        end
    end

    // Single write port, AMO has priority but drains are stalled anyway
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (amo_phase_q) begin
            mem_q[amo_idx] <= amo_wdata;
        end else if (drain_done_o) begin
            mem_q[drain_idx] <= drain_wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            amo_phase_q <= 1'b0;
            amo_ack_q   <= 1'b0;
        end else begin
            amo_phase_q <= amo_start;
            amo_ack_q   <= amo_phase_q;  // Rises at the write edge
        end
    end

    always_ff @(posedge clk_i) begin
        if (amo_start) begin
            amo_old_q <= mem_q[amo_idx];
        end
        if (amo_phase_q) begin
            amo_result_q <= op_a;
        end
        if (ld_req_i) begin
            ld_data_q <= mem_q[ld_idx];
        end
    end

    assign amo_ack_o    = amo_ack_q;
    assign amo_result_o = amo_result_q;
    assign ld_data_o    = ld_data_q;

endmodule

`default_nettype wire

// ==== hw/store_buffer.sv ====
/*
 * Circular store queue with speculative and committed regions
 * Flush drops every uncommitted entry, committed ones still drain
 * Only a committed head is offered to memory, one drain per cycle
 */
`default_nettype none

module store_buffer
    import amo_lsu_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            flush_i,          // Drop speculative stores

    input  logic            st_valid_i,
    input  logic [PLEN-1:0] st_paddr_i,
    input  logic [XLEN-1:0] st_data_i,
    input  logic [1:0]      st_size_i,
    input  logic            st_commit_i,      // Pulse, commits the oldest speculative entry
    output logic            st_ready_o,

    output logic            drain_valid_o,    // Committed head available
    output logic [PLEN-1:0] drain_paddr_o,
    output logic [XLEN-1:0] drain_data_o,
    output logic [1:0]      drain_size_o,
    input  logic            drain_done_i,     // Head written this cycle

    output logic            no_st_pending_o   // Queue completely empty
);

    // Entry payload
    logic [PLEN-1:0] paddr_q [STORE_DEPTH];
    logic [XLEN-1:0] data_q  [STORE_DEPTH];
    logic [1:0]      size_q  [STORE_DEPTH];

    logic [SB_PTR_W-1:0] wr_ptr_q;      // Next free slot
    logic [SB_PTR_W-1:0] commit_ptr_q;  // Oldest speculative entry
    logic [SB_PTR_W-1:0] rd_ptr_q;      // Oldest committed entry
    logic [SB_PTR_W-1:0] commit_ptr_nxt;
    logic [SB_CNT_W-1:0] spec_cnt_q;    // Entries not yet committed
    logic [SB_CNT_W-1:0] com_cnt_q;     // Committed, waiting to drain
    logic [SB_CNT_W-1:0] used;

    logic push;
    logic commit;
    logic drain;

    assign used       = spec_cnt_q + com_cnt_q;
    assign st_ready_o = used != SB_CNT_W'(STORE_DEPTH);  // Back-pressure when full

    // A push in a flush cycle is speculative too, so it is dropped
    assign push   = st_valid_i & st_ready_o & ~flush_i;
    assign commit = st_commit_i & (spec_cnt_q != '0);  // Stray commit pulses ignored
    assign drain  = drain_done_i & (com_cnt_q != '0);

    assign commit_ptr_nxt = commit ? commit_ptr_q + 1'b1 : commit_ptr_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q     <= '0;
            commit_ptr_q <= '0;
            rd_ptr_q     <= '0;
            spec_cnt_q   <= '0;
            com_cnt_q    <= '0;
        end else begin
            commit_ptr_q <= commit_ptr_nxt;
            if (drain) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Commit in the flush cycle still counts, rewind behind it
            if (flush_i) begin
                wr_ptr_q   <= commit_ptr_nxt;
                spec_cnt_q <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                spec_cnt_q <= spec_cnt_q + SB_CNT_W'(push) - SB_CNT_W'(commit);
            end
            com_cnt_q <= com_cnt_q + SB_CNT_W'(commit) - SB_CNT_W'(drain);
        end
    end

    // Payload write, slot is free whenever push is allowed
    always_ff @(posedge clk_i) begin
        if (push) begin
            paddr_q[wr_ptr_q] <= st_paddr_i;
            data_q[wr_ptr_q]  <= st_data_i;
            size_q[wr_ptr_q]  <= st_size_i;
        end
    end

    assign drain_valid_o = com_cnt_q != '0;
    assign drain_paddr_o = paddr_q[rd_ptr_q];
    assign drain_data_o  = data_q[rd_ptr_q];
    assign drain_size_o  = size_q[rd_ptr_q];

    // AMO must also wait for younger speculative stores to leave
    assign no_st_pending_o = (spec_cnt_q == '0) & (com_cnt_q == '0);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the AMO load/store path testbench with Verilator and run it
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module amo_lsu_tb \
    -f amo_lsu.f \
    -o sim_amo_lsu

./obj_dir/sim_amo_lsu | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Simulation finished cleanly"

// ==== verification/amo_lsu_properties.sv ====
/*
 * Handshake assertions for the AMO buffer, attached by bind
 * Expects the two-cycle request to ack latency of the memory unit
 * drain_done comes from the top level through a hierarchical path
 */
`default_nettype none

module amo_lsu_properties (
    input logic clk_i,
    input logic reset_i,
    input logic amo_req_i,
    input logic amo_ready_i,
    input logic amo_ack_i,
    input logic drain_done_i
);

    // Request and held entry last until the ack
    req_holds_entry: assert property (@(posedge clk_i) disable iff (reset_i)
        amo_req_i && !amo_ack_i |=> amo_req_i && !amo_ready_i)
        else $error("AMO request dropped or buffer freed before the ack");

    // Read, then modify and write, then ack
    ack_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
        amo_ack_i |-> $past(amo_req_i, 2))
        else $error("AMO ack without a request two cycles earlier");

    // No store drain from the request edge through the ack
    no_drain_in_amo: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(amo_req_i) |-> (!drain_done_i) [*3])
        else $error("Store drained while an AMO was active");

endmodule

`default_nettype wire

// ==== verification/amo_lsu_tb.sv ====
/*
 * Directed testbench for amo_lsu_top, inputs change on rising edges
 * Outputs are sampled on falling edges, loads return whole doublewords
 * Reference memory is updated at commit, checks wait for the drain
 */
`default_nettype none

module amo_lsu_tb import amo_lsu_pkg::*; ();

    localparam int TIMEOUT = 200;  // Cycles per wait loop

    logic            clk_i;
    logic            reset_i;
    logic            flush_i;
    logic            st_valid_i;
    logic [PLEN-1:0] st_paddr_i;
    logic [XLEN-1:0] st_data_i;
    logic [1:0]      st_size_i;
    logic            st_commit_i;
    logic            st_ready_o;
    logic            amo_valid_i;
    amo_op_e         amo_op_i;
    logic [PLEN-1:0] amo_paddr_i;
    logic [XLEN-1:0] amo_data_i;
    logic [1:0]      amo_size_i;
    logic            amo_ready_o;
    logic            amo_valid_commit_i;
    logic            amo_ack_o;
    logic [XLEN-1:0] amo_result_o;
    logic            ld_req_i;
    logic [PLEN-1:0] ld_paddr_i;
    logic [XLEN-1:0] ld_data_o;

    logic [XLEN-1:0] ref_mem [MEM_WORDS];  // Expected memory contents
    logic [PLEN-1:0] pend_addr [$];        // Uncommitted stores, oldest first
    logic [XLEN-1:0] pend_data [$];
    logic [1:0]      pend_size [$];
    int              err_count;
    int              check_count;

    amo_lsu_top DUT (.*);

    bind amo_buffer amo_lsu_properties props_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .amo_req_i    (amo_req_o),
        .amo_ready_i  (amo_ready_o),
        .amo_ack_i    (amo_ack_i),
        .drain_done_i (amo_lsu_tb.DUT.drain_done)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin  // Hard stop in case a wait loop misbehaves
        #200000;
        $display("Simulation watchdog expired before the tests ended");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [PLEN-1:0] make_addr(int idx, bit hi);
        return PLEN'(idx * 8 + (hi ? 4 : 0));
    endfunction

    // Store rule, a word store replaces only its half
    function automatic void ref_store(logic [PLEN-1:0] a, logic [XLEN-1:0] d, logic [1:0] s);
        if (s == SIZE_D) begin
            ref_mem[a[6:3]] = d;
        end else if (a[2]) begin
            ref_mem[a[6:3]][63:32] = d[31:0];
        end else begin
            ref_mem[a[6:3]][31:0] = d[31:0];
        end
    endfunction

    // Returns the old value, sign-extended for words, and updates memory
    function automatic logic [XLEN-1:0] ref_amo(amo_op_e op, logic [PLEN-1:0] a,
                                                logic [XLEN-1:0] d, logic [1:0] s);
        logic [63:0] old;
        logic [63:0] res;
        logic [31:0] ow;
        logic [31:0] rw;
        old = ref_mem[a[6:3]];
        if (s == SIZE_D) begin
            case (op)
                AMO_SWAP: res = d;
                AMO_ADD:  res = old + d;
                AMO_AND:  res = old & d;
                AMO_OR:   res = old | d;
                AMO_XOR:  res = old ^ d;
                AMO_MAX:  res = ($signed(old) > $signed(d)) ? old : d;
                AMO_MAXU: res = (old > d) ? old : d;
                AMO_MIN:  res = ($signed(old) < $signed(d)) ? old : d;
                AMO_MINU: res = (old < d) ? old : d;
                default:  res = old;
            endcase
            ref_mem[a[6:3]] = res;
            return old;
        end
        ow = a[2] ? old[63:32] : old[31:0];
        case (op)
            AMO_SWAP: rw = d[31:0];
            AMO_ADD:  rw = ow + d[31:0];
            AMO_AND:  rw = ow & d[31:0];
            AMO_OR:   rw = ow | d[31:0];
            AMO_XOR:  rw = ow ^ d[31:0];
            AMO_MAX:  rw = ($signed(ow) > $signed(d[31:0])) ? ow : d[31:0];
            AMO_MAXU: rw = (ow > d[31:0]) ? ow : d[31:0];
            AMO_MIN:  rw = ($signed(ow) < $signed(d[31:0])) ? ow : d[31:0];
            AMO_MINU: rw = (ow < d[31:0]) ? ow : d[31:0];
            default:  rw = ow;
        endcase
        if (a[2]) ref_mem[a[6:3]][63:32] = rw;
        else ref_mem[a[6:3]][31:0] = rw;
        return {{32{ow[31]}}, ow};
    endfunction

    task automatic check_load(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: load %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_amo(amo_op_e op, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s result %h expected %h", $time, op.name(), got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t: %s is %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(string what);
        err_count++;
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    endtask

    task automatic push_store(logic [PLEN-1:0] a, logic [XLEN-1:0] d, logic [1:0] s);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!st_ready_o && n < TIMEOUT) begin  // Back-pressure from a full queue
            n++;
            @(negedge clk_i);
        end
        if (n >= TIMEOUT) timed_out("st_ready_o");
        @(posedge clk_i);
        st_valid_i <= 1'b1;
        st_paddr_i <= a;
        st_data_i  <= d;
        st_size_i  <= s;
        @(posedge clk_i);
        st_valid_i <= 1'b0;
        pend_addr.push_back(a);
        pend_data.push_back(d);
        pend_size.push_back(s);
    endtask

    task automatic commit_store();
        @(posedge clk_i);
        st_commit_i <= 1'b1;
        @(posedge clk_i);
        st_commit_i <= 1'b0;
        ref_store(pend_addr.pop_front(), pend_data.pop_front(), pend_size.pop_front());
    endtask

    task automatic flush_pulse();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        pend_addr.delete();
        pend_data.delete();
        pend_size.delete();
    endtask

    task automatic do_load(logic [PLEN-1:0] a, output logic [XLEN-1:0] d);
        @(posedge clk_i);
        ld_req_i   <= 1'b1;
        ld_paddr_i <= a;
        @(posedge clk_i);
        ld_req_i <= 1'b0;
        @(negedge clk_i);
        d = ld_data_o;  // Captured at the edge after the request
    endtask

    // Polls by loads until the last committed store is visible
    task automatic wait_drained(logic [PLEN-1:0] a);
        logic [XLEN-1:0] d;
        int n;
        n = 0;
        do_load(a, d);
        while (d !== ref_mem[a[6:3]] && n < TIMEOUT) begin
            n++;
            do_load(a, d);
        end
        if (n >= TIMEOUT) timed_out("committed stores to drain");
    endtask

    task automatic load_and_check(string what, logic [PLEN-1:0] a);
        logic [XLEN-1:0] d;
        do_load(a, d);
        check_load(what, d, ref_mem[a[6:3]]);
    endtask

    task automatic push_amo(amo_op_e op, logic [PLEN-1:0] a, logic [XLEN-1:0] d,
                            logic [1:0] s);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!amo_ready_o && n < TIMEOUT) begin
            n++;
            @(negedge clk_i);
        end
        if (n >= TIMEOUT) timed_out("amo_ready_o");
        @(posedge clk_i);
        amo_valid_i <= 1'b1;
        amo_op_i    <= op;
        amo_paddr_i <= a;
        amo_data_i  <= d;
        amo_size_i  <= s;
        @(posedge clk_i);
        amo_valid_i <= 1'b0;
    endtask

    // Holds commit low for hold cycles, then raises it and times the ack
    // With st_too the oldest pending store commits in the same cycle
    task automatic commit_amo(amo_op_e op, logic [PLEN-1:0] a, logic [XLEN-1:0] d,
                              logic [1:0] s, int hold, bit flush_too, bit st_too);
        int n;
        int req_cyc;
        logic [XLEN-1:0] exp;
        repeat (hold) begin
            @(negedge clk_i);
            check_flag("amo_ack_o before commit", amo_ack_o, 1'b0);
        end
        @(posedge clk_i);
        amo_valid_commit_i <= 1'b1;
        flush_i            <= flush_too;  // Must not discard an AMO at commit
        st_commit_i        <= st_too;     // Store still in the queue when the AMO commits
        if (st_too) begin
            ref_store(pend_addr.pop_front(), pend_data.pop_front(), pend_size.pop_front());
        end
        n       = 0;
        req_cyc = -1;
        forever begin
            @(negedge clk_i);
            if (DUT.amo_req && req_cyc < 0) req_cyc = n;
            if (amo_ack_o) break;
            n++;
            if (n >= TIMEOUT) break;
            @(posedge clk_i);
            flush_i     <= 1'b0;
            st_commit_i <= 1'b0;
        end
        if (n >= TIMEOUT) begin
            timed_out("amo_ack_o");
        end else begin
            exp = ref_amo(op, a, d, s);
            if (req_cyc < 0) begin
                err_count++;
                $display("AMO ack seen without the request ever rising");
            end else if (n != req_cyc + 2) begin
                err_count++;
                $display("** Error at %0t: ack %0d cycles after request, expected 2",
                         $time, n - req_cyc);
            end
            check_amo(op, amo_result_o, exp);
        end
        @(posedge clk_i);
        amo_valid_commit_i <= 1'b0;
        flush_i            <= 1'b0;
        st_commit_i        <= 1'b0;
        load_and_check("after AMO", a);
    endtask

    task automatic stores_to_loads();
        int idx;
        logic [PLEN-1:0] a;
        idx = int'($urandom % 16);
        a = make_addr(idx, 1'b0);
        push_store(a, {$urandom, $urandom}, SIZE_D);
        push_store(make_addr(idx, 1'b1), {$urandom, $urandom}, SIZE_W);  // Upper half
        push_store(make_addr((idx + 5) % 16, 1'b0), {$urandom, $urandom}, SIZE_W);
        repeat (3) commit_store();
        wait_drained(make_addr((idx + 5) % 16, 1'b0));
        load_and_check("64/32 bit store", a);
        load_and_check("low word store", make_addr((idx + 5) % 16, 1'b0));
    endtask

    task automatic store_flush();
        push_store(make_addr(2, 1'b0), {$urandom, $urandom}, SIZE_D);
        push_store(make_addr(3, 1'b0), {$urandom, $urandom}, SIZE_D);
        push_store(make_addr(4, 1'b1), {$urandom, $urandom}, SIZE_W);
        commit_store();
        flush_pulse();  // Stores to index 3 and 4 are dropped
        wait_drained(make_addr(2, 1'b0));
        repeat (4) @(posedge clk_i);
        load_and_check("committed before flush", make_addr(2, 1'b0));
        load_and_check("flushed store 3", make_addr(3, 1'b0));
        load_and_check("flushed store 4", make_addr(4, 1'b0));
    endtask

    task automatic amo_all_ops();
        amo_op_e op;
        logic [PLEN-1:0] a;
        logic [XLEN-1:0] d;
        logic [1:0] s;
        for (int sz = 0; sz < 2; sz++) begin
            op = AMO_SWAP;
            for (int k = 0; k < 9; k++) begin
                s = (sz == 0) ? SIZE_D : SIZE_W;
                a = make_addr(int'($urandom % 16), 1'($urandom));
                push_store(make_addr(a[6:3], 1'b0), {$urandom, $urandom}, SIZE_D);
                commit_store();
                wait_drained(a);
                d = {$urandom, $urandom};
                push_amo(op, a, d, s);
                commit_amo(op, a, d, s, 0, 1'b0, 1'b0);
                op = op.next();
            end
        end
    endtask

    task automatic amo_ordering();
        logic [PLEN-1:0] a;
        logic [XLEN-1:0] d;
        a = make_addr(9, 1'b1);
        d = {$urandom, $urandom};
        push_amo(AMO_ADD, a, d, SIZE_W);  // Queue empty, only commit holds it back
        commit_amo(AMO_ADD, a, d, SIZE_W, 5, 1'b0, 1'b0);
        push_store(make_addr(9, 1'b0), {$urandom, $urandom}, SIZE_D);
        push_store(a, {$urandom, $urandom}, SIZE_W);
        commit_store();
        d = {$urandom, $urandom};
        push_amo(AMO_ADD, a, d, SIZE_W);  // Result must include both stores
        commit_amo(AMO_ADD, a, d, SIZE_W, 0, 1'b0, 1'b1);
    endtask

    task automatic amo_flush();
        logic [PLEN-1:0] a;
        logic [XLEN-1:0] d;
        a = make_addr(12, 1'b0);
        d = {$urandom, $urandom};
        push_amo(AMO_SWAP, a, d, SIZE_D);
        @(negedge clk_i);
        check_flag("amo_ready_o while held", amo_ready_o, 1'b0);
        flush_pulse();
        @(negedge clk_i);
        check_flag("amo_ready_o after flush", amo_ready_o, 1'b1);
        load_and_check("memory after dropped AMO", a);
        push_amo(AMO_XOR, a, d, SIZE_D);
        commit_amo(AMO_XOR, a, d, SIZE_D, 1, 1'b1, 1'b0);  // Flush at commit keeps it
    endtask

    task automatic queue_full();
        for (int i = 0; i < STORE_DEPTH; i++) begin
            push_store(make_addr(i + 8, 1'b0), {$urandom, $urandom}, SIZE_D);
        end
        @(negedge clk_i);
        check_flag("st_ready_o when full", st_ready_o, 1'b0);
        commit_store();
        push_store(make_addr(13, 1'b0), {$urandom, $urandom}, SIZE_D);  // Waits for room
        repeat (STORE_DEPTH) commit_store();
        wait_drained(make_addr(13, 1'b0));
        for (int i = 8; i < 14; i++) begin
            load_and_check("after full queue", make_addr(i, 1'b0));
        end
    endtask

    initial begin
        void'($urandom(32'h31d7));
        err_count   = 0;
        check_count = 0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;
        reset_i            <= 1'b1;
        flush_i            <= 1'b0;
        st_valid_i         <= 1'b0;
        st_paddr_i         <= '0;
        st_data_i          <= '0;
        st_size_i          <= SIZE_D;
        st_commit_i        <= 1'b0;
        amo_valid_i        <= 1'b0;
        amo_op_i           <= AMO_NONE;
        amo_paddr_i        <= '0;
        amo_data_i         <= '0;
        amo_size_i         <= SIZE_D;
        amo_valid_commit_i <= 1'b0;
        ld_req_i           <= 1'b0;
        ld_paddr_i         <= '0;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_flag("st_ready_o after reset", st_ready_o, 1'b1);
        check_flag("amo_ready_o after reset", amo_ready_o, 1'b1);
        check_flag("amo_ack_o after reset", amo_ack_o, 1'b0);

        stores_to_loads();
        store_flush();
        amo_all_ops();
        amo_ordering();
        amo_flush();
        queue_full();

        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
